// File: init_table_pkg.sv
// init table package: entry and index types, command codes, table length and codec masks
`default_nettype none

package init_table_pkg;

    // number of entries in the start-up table
    localparam int TABLE_LEN = 43;

    // one table entry, tag bits at the top
    typedef logic [8:0] table_entry_t;

    // table position, wide enough for every entry
    typedef logic [$clog2(TABLE_LEN)-1:0] table_index_t;

    // end of table, closes the bus and ends the run
    localparam table_entry_t ENTRY_STOP = 9'b000000000;

    // bus stop without leaving the table
    localparam table_entry_t ENTRY_SEND_STOP = 9'b001000001;

    // 1 dddddddd: write one data byte
    localparam logic TAG_DATA = 1'b1;

    // 01 aaaaaaa: start write to a 7-bit address
    localparam logic [1:0] TAG_ADDR = 2'b01;

    // codec register 02h data byte, rewritten on a config change
    localparam table_index_t PATCH_INDEX = 6'd41;

    // start write entry in front of the 02h register write
    localparam table_index_t RESTART_INDEX = 6'd39;

    // signal select 1 bits that never change
    localparam logic [7:0] CODEC_SEL1_BASE = 8'h2a;

    // mic gain stage selection
    localparam logic [7:0] MIC_BOOST_ON = 8'h40;
    localparam logic [7:0] MIC_BOOST_OFF = 8'h04;

    // speaker amp power bit
    localparam logic [7:0] SPK_ON = 8'h80;

endpackage

`default_nettype wire

// File: i2c_cmd_pkg.sv
// i2c command package: address and byte types, master command and sequencer operation
`default_nettype none

package i2c_cmd_pkg;

    // 7-bit device address on the bus
    typedef logic [6:0] i2c_addr_t;

    // one data byte toward the master
    typedef logic [7:0] i2c_byte_t;

    // command word for the i2c master, 10 bits
    typedef struct packed {
        i2c_addr_t address;
        logic      start;
        logic      write;
        logic      stop;
    } i2c_cmd_t;

    // what the sequencer asks of the output side
    typedef enum logic [1:0] {
        OP_SET_ADDR,
        OP_WRITE,
        OP_STOP
    } seq_op_kind_t;

    // one operation, address and byte taken from the same entry
    typedef struct packed {
        seq_op_kind_t kind;
        i2c_addr_t    addr;
        i2c_byte_t    data;
    } seq_op_t;

endpackage

`default_nettype wire

// File: cfg_sync.sv
// cfg_sync: pin synchronisers, change detect and patched codec byte
`timescale 1ns/10ps
`default_nettype none

module cfg_sync
    import init_table_pkg::*, i2c_cmd_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       spk_enable,
    input  wire       mic_boost,
    output logic      cfg_change,
    output i2c_byte_t patch_byte
);

    // both config pins side by side
    typedef struct packed {
        logic spk;
        logic mic;
    } cfg_pins_t;

    // flop chain, stage 0 sees the raw async pins
    cfg_pins_t sync_q [SYNC_STAGES];
    // last synchronised state already taken into account
    cfg_pins_t last_q;
    cfg_pins_t pins_sync;

    assign pins_sync = sync_q[SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            last_q     <= '0;
            cfg_change <= 1'b0;
        end else begin
            sync_q[0] <= '{spk: spk_enable, mic: mic_boost};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            last_q <= pins_sync;
            // single pulse, next cycle last_q has caught up
            cfg_change <= (pins_sync != last_q);
        end
    end

    // new register 02h value, valid while cfg_change is high
    always_comb begin
        patch_byte = CODEC_SEL1_BASE;
        patch_byte = patch_byte | (last_q.mic ? MIC_BOOST_ON : MIC_BOOST_OFF);
        if (last_q.spk) begin
            patch_byte = patch_byte | SPK_ON;
        end
    end

endmodule

`default_nettype wire

// File: init_table.sv
// init_table: board start-up table, patchable codec entry, registered read port
`timescale 1ns/10ps
`default_nettype none

module init_table
    import init_table_pkg::*, i2c_cmd_pkg::*;
(
    input  wire          clk,
    input  table_index_t rd_index,
    input  wire          cfg_change,
    input  i2c_byte_t    patch_byte,
    output table_entry_t entry
);

    // devices on the board
    localparam i2c_addr_t CLKGEN_ADDR = 7'h6a;
    localparam i2c_addr_t CODEC_ADDR = 7'h12;

    // register 02h: speaker on, boost off
    localparam i2c_byte_t SEL1_DEFAULT = 8'hae;

    // writable entry, loaded with the power-up value
    table_entry_t patch_q = {TAG_DATA, SEL1_DEFAULT};

    function automatic table_entry_t addr_e(input i2c_addr_t a);
        return {TAG_ADDR, a};
    endfunction

    function automatic table_entry_t data_e(input i2c_byte_t b);
        return {TAG_DATA, b};
    endfunction

    // fixed part, each group is address then register then value
    function automatic table_entry_t rom_entry(input table_index_t idx);
        case (idx)
            // clock generator setup
            6'd0:  return addr_e(CLKGEN_ADDR);
            6'd1:  return data_e(8'h17);
            6'd2:  return data_e(8'h04);
            6'd3:  return addr_e(CLKGEN_ADDR);
            6'd4:  return data_e(8'h18);
            6'd5:  return data_e(8'h40);
            6'd6:  return addr_e(CLKGEN_ADDR);
            6'd7:  return data_e(8'h1e);
            6'd8:  return data_e(8'he8);
            6'd9:  return addr_e(CLKGEN_ADDR);
            6'd10: return data_e(8'h1f);
            6'd11: return data_e(8'h80);
            6'd12: return addr_e(CLKGEN_ADDR);
            6'd13: return data_e(8'h2d);
            6'd14: return data_e(8'h01);
            6'd15: return addr_e(CLKGEN_ADDR);
            6'd16: return data_e(8'h2e);
            6'd17: return data_e(8'h10);
            6'd18: return addr_e(CLKGEN_ADDR);
            6'd19: return data_e(8'h60);
            6'd20: return data_e(8'h3b);
            // codec, dummy write to 00h first
            6'd21: return addr_e(CODEC_ADDR);
            6'd22: return data_e(8'h00);
            6'd23: return data_e(8'h00);
            // mode control 1, pll and audio format
            6'd24: return addr_e(CODEC_ADDR);
            6'd25: return data_e(8'h05);
            6'd26: return data_e(8'h33);
            // power management 1
            6'd27: return addr_e(CODEC_ADDR);
            6'd28: return data_e(8'h00);
            6'd29: return data_e(8'hc5);
            // power management 2, speaker path up
            6'd30: return addr_e(CODEC_ADDR);
            6'd31: return data_e(8'h01);
            6'd32: return data_e(8'hb6);
            // signal select 3
            6'd33: return addr_e(CODEC_ADDR);
            6'd34: return data_e(8'h04);
            6'd35: return data_e(8'h47);
            // signal select 2, default speaker gain
            6'd36: return addr_e(CODEC_ADDR);
            6'd37: return data_e(8'h03);
            6'd38: return data_e(8'h00);
            // signal select 1, value lives in patch_q
            6'd39: return addr_e(CODEC_ADDR);
            6'd40: return data_e(8'h02);
            // 42 and anything past the end reads as stop
            default: return ENTRY_STOP;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (cfg_change) begin
            patch_q <= {TAG_DATA, patch_byte};
        end
    end

    // read of the patched entry sees a write in the same cycle
    always_ff @(posedge clk) begin
        if (rd_index == PATCH_INDEX) begin
            entry <= cfg_change ? {TAG_DATA, patch_byte} : patch_q;
        end else begin
            entry <= rom_entry(rd_index);
        end
    end

endmodule

`default_nettype wire

// File: init_sequencer.sv
// init_sequencer: table walk FSM, start handling and entry decode
`timescale 1ns/10ps
`default_nettype none

module init_sequencer
    import init_table_pkg::*, i2c_cmd_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          init_start,
    input  wire          cfg_change,
    input  table_entry_t entry,
    input  wire          out_idle,
    output table_index_t rd_index,
    output seq_op_t      op,
    output logic         op_strobe,
    output logic         busy
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_t;

    state_t       state_q;
    state_t       state_d;
    // index of the entry currently held on the entry input
    table_index_t index_q;
    table_index_t index_d;

    // set while a taken init_start is still high
    logic start_flag_q;
    // config change seen while a run was going on
    logic change_pend_q;
    logic busy_q;

    logic restart_req;
    logic full_req;
    logic run_accept;

    assign restart_req = cfg_change | change_pend_q;
    assign full_req = init_start & ~start_flag_q;
    // new run only once the last stop has left the output side
    assign run_accept = (state_q == ST_IDLE) & out_idle & (restart_req | full_req);

    always_comb begin
        state_d   = state_q;
        index_d   = index_q;
        op_strobe = 1'b0;
        // address and byte fields come straight from the entry
        op.kind = OP_WRITE;
        op.addr = entry[6:0];
        op.data = entry[7:0];

        case (state_q)
            ST_IDLE: begin
                if (run_accept) begin
                    // a replay only redoes the 02h write
                    index_d = restart_req ? RESTART_INDEX : '0;
                    state_d = ST_RUN;
                end
            end
            ST_RUN: begin
                // output side busy, hold index so nothing is lost
                if (out_idle) begin
                    index_d = index_q + 1'b1;
                    if (entry[8] == TAG_DATA) begin
                        op.kind   = OP_WRITE;
                        op_strobe = 1'b1;
                    end else if (entry[8:7] == TAG_ADDR) begin
                        // only latches the address, no bus traffic
                        op.kind   = OP_SET_ADDR;
                        op_strobe = 1'b1;
                    end else if (entry == ENTRY_SEND_STOP) begin
                        op.kind   = OP_STOP;
                        op_strobe = 1'b1;
                    end else if (entry == ENTRY_STOP) begin
                        // final bus stop, then done
                        op.kind   = OP_STOP;
                        op_strobe = 1'b1;
                        index_d   = index_q;
                        state_d   = ST_IDLE;
                    end
                    // any other code is skipped
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // table read follows the next index, entry lines up a cycle later
    assign rd_index = index_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= ST_IDLE;
            index_q       <= '0;
            start_flag_q  <= 1'b0;
            change_pend_q <= 1'b0;
            busy_q        <= 1'b0;
        end else begin
            state_q <= state_d;
            index_q <= index_d;

            // one run per start request, flag drops with the request
            start_flag_q <= init_start & (start_flag_q | (run_accept & ~restart_req));

            // change wins over start, full run follows later
            if (run_accept && restart_req) begin
                change_pend_q <= 1'b0;
            end else if (cfg_change) begin
                change_pend_q <= 1'b1;
            end

            // busy ends once the stop command is taken
            if (run_accept) begin
                busy_q <= 1'b1;
            end else if (state_q == ST_IDLE && out_idle) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign busy = busy_q;

endmodule

`default_nettype wire

// File: i2c_cmd_out.sv
// i2c_cmd_out: command and data registers toward the master with valid/ready
`timescale 1ns/10ps
`default_nettype none

module i2c_cmd_out
    import i2c_cmd_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  seq_op_t   op,
    input  wire       op_strobe,
    input  wire       cmd_ready,
    input  wire       data_ready,
    output i2c_cmd_t  cmd,
    output logic      cmd_valid,
    output i2c_byte_t data_out,
    output logic      data_valid,
    output logic      out_idle
);

    // device address from the last set-address op
    i2c_addr_t addr_q;
    // next write opens a new transfer
    logic      start_pend_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid    <= 1'b0;
            data_valid   <= 1'b0;
            start_pend_q <= 1'b0;
        end else begin
            // each valid drops on its own handshake
            if (cmd_valid && cmd_ready) begin
                cmd_valid    <= 1'b0;
                start_pend_q <= 1'b0;
            end
            if (data_valid && data_ready) begin
                data_valid <= 1'b0;
            end
            if (op_strobe) begin
                case (op.kind)
                    OP_SET_ADDR: start_pend_q <= 1'b1;
                    OP_WRITE: begin
                        cmd_valid  <= 1'b1;
                        data_valid <= 1'b1;
                    end
                    OP_STOP: cmd_valid <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // payload only changes on a strobe, so it is stable while valid
    always_ff @(posedge clk) begin
        if (op_strobe) begin
            case (op.kind)
                OP_SET_ADDR: addr_q <= op.addr;
                OP_WRITE: begin
                    cmd      <= '{address: addr_q, start: start_pend_q, write: 1'b1,
                                  stop: 1'b0};
                    data_out <= op.data;
                end
                OP_STOP: cmd <= '{address: addr_q, start: 1'b0, write: 1'b0, stop: 1'b1};
                default: ;
            endcase
        end
    end

    assign out_idle = ~cmd_valid & ~data_valid;

endmodule

`default_nettype wire

// File: codec_init_top.sv
// codec_init_top: config sync, table, sequencer and master-side output stage
`timescale 1ns/10ps
`default_nettype none

module codec_init_top
    import init_table_pkg::*, i2c_cmd_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       init_start,
    input  wire       spk_enable,
    input  wire       mic_boost,
    input  wire       cmd_ready,
    input  wire       data_ready,
    output i2c_cmd_t  cmd,
    output logic      cmd_valid,
    output i2c_byte_t data_out,
    output logic      data_valid,
    output logic      busy
);

    // config side to table and sequencer
    logic         cfg_change;
    i2c_byte_t    patch_byte;
    // table read port
    table_index_t rd_index;
    table_entry_t entry;
    // sequencer to output stage
    seq_op_t      op;
    logic         op_strobe;
    logic         out_idle;

    cfg_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_cfg_sync (
        .clk        (clk),
        .rst        (rst),
        .spk_enable (spk_enable),
        .mic_boost  (mic_boost),
        .cfg_change (cfg_change),
        .patch_byte (patch_byte)
    );

    init_table u_init_table (
        .clk        (clk),
        .rd_index   (rd_index),
        .cfg_change (cfg_change),
        .patch_byte (patch_byte),
        .entry      (entry)
    );

    init_sequencer u_init_sequencer (
        .clk        (clk),
        .rst        (rst),
        .init_start (init_start),
        .cfg_change (cfg_change),
        .entry      (entry),
        .out_idle   (out_idle),
        .rd_index   (rd_index),
        .op         (op),
        .op_strobe  (op_strobe),
        .busy       (busy)
    );

    i2c_cmd_out u_i2c_cmd_out (
        .clk        (clk),
        .rst        (rst),
        .op         (op),
        .op_strobe  (op_strobe),
        .cmd_ready  (cmd_ready),
        .data_ready (data_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .data_out   (data_out),
        .data_valid (data_valid),
        .out_idle   (out_idle)
    );

endmodule

`default_nettype wire

// File: tb_codec_init.sv
// directed testbench for codec_init_top with a master model and checks
`timescale 1ns/10ps
`default_nettype none

module tb_codec_init
    import i2c_cmd_pkg::*;
();

    localparam int NUM_GROUPS = 14;
    localparam int RUN_TIMEOUT = 2000;
    localparam int IDLE_TIMEOUT = 50;
    localparam logic [31:0] SEED = 32'h657b5ad7;

    // device, register and value of each board write group
    localparam i2c_addr_t GRP_ADDR [NUM_GROUPS] = '{
        7'h6a, 7'h6a, 7'h6a, 7'h6a, 7'h6a, 7'h6a, 7'h6a,
        7'h12, 7'h12, 7'h12, 7'h12, 7'h12, 7'h12, 7'h12
    };
    localparam i2c_byte_t GRP_REG [NUM_GROUPS] = '{
        8'h17, 8'h18, 8'h1e, 8'h1f, 8'h2d, 8'h2e, 8'h60,
        8'h00, 8'h05, 8'h00, 8'h01, 8'h04, 8'h03, 8'h02
    };
    // last value is the codec 02h byte that a patch replaces
    localparam i2c_byte_t GRP_VAL [NUM_GROUPS] = '{
        8'h04, 8'h40, 8'he8, 8'h80, 8'h01, 8'h10, 8'h3b,
        8'h00, 8'h33, 8'hc5, 8'hb6, 8'h47, 8'h00, 8'hae
    };

    logic      clk;
    logic      rst;
    logic      init_start;
    logic      spk_enable;
    logic      mic_boost;
    logic      cmd_ready;
    logic      data_ready;
    i2c_cmd_t  cmd;
    logic      cmd_valid;
    i2c_byte_t data_out;
    logic      data_valid;
    logic      busy;

    // expected and collected transfers
    i2c_cmd_t  exp_cmds [$];
    i2c_byte_t exp_data [$];
    i2c_cmd_t  got_cmds [$];
    i2c_byte_t got_data [$];

    string test_name;
    // cycles spent by the last collected run
    int    run_cycles;
    // length of an unstalled full run as measured by the first one
    int    full_run_cycles;

    codec_init_top #(
        .SYNC_STAGES(2)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .init_start (init_start),
        .spk_enable (spk_enable),
        .mic_boost  (mic_boost),
        .cmd_ready  (cmd_ready),
        .data_ready (data_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .data_out   (data_out),
        .data_valid (data_valid),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch in %s", test_name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in %s: %s", test_name, what);
        $display("tests failed");
        $fatal(1, "simulation stopped on a timeout");
    endtask

    // codec 02h byte from the pin levels
    function automatic i2c_byte_t expected_sel1(input logic spk, input logic mic);
        return 8'h2a | (mic ? 8'h40 : 8'h04) | (spk ? 8'h80 : 8'h00);
    endfunction

    // start write with byte 1, plain write with byte 2, one stop at the end
    task automatic build_expected(input int first_grp, input i2c_byte_t sel1_val);
        i2c_cmd_t c;
        exp_cmds.delete();
        exp_data.delete();
        for (int g = first_grp; g < NUM_GROUPS; g++) begin
            c = '{address: GRP_ADDR[g], start: 1'b1, write: 1'b1, stop: 1'b0};
            exp_cmds.push_back(c);
            c = '{address: GRP_ADDR[g], start: 1'b0, write: 1'b1, stop: 1'b0};
            exp_cmds.push_back(c);
            exp_data.push_back(GRP_REG[g]);
            exp_data.push_back((g == NUM_GROUPS - 1) ? sel1_val : GRP_VAL[g]);
        end
        c = '{address: GRP_ADDR[NUM_GROUPS-1], start: 1'b0, write: 1'b0, stop: 1'b1};
        exp_cmds.push_back(c);
    endtask

    // master model that records transfers up to the stop command
    task automatic collect_run(input logic stalls);
        logic      done;
        logic      cmd_held;
        logic      data_held;
        i2c_cmd_t  cmd_prev;
        i2c_byte_t data_prev;
        int        n;
        got_cmds.delete();
        got_data.delete();
        done = 1'b0;
        cmd_held = 1'b0;
        data_held = 1'b0;
        cmd_prev = '0;
        data_prev = '0;
        n = 0;
        while (!done) begin
            @(negedge clk);
            if (n == RUN_TIMEOUT) begin
                report_timeout("no stop command from the DUT");
            end
            n++;
            // a stalled payload must not move
            if (cmd_held) begin
                check_value("cmd_valid held", 32'd1, 32'(cmd_valid));
                check_value("cmd held", 32'(cmd_prev), 32'(cmd));
            end
            if (data_held) begin
                check_value("data_valid held", 32'd1, 32'(data_valid));
                check_value("data held", 32'(data_prev), 32'(data_out));
            end
            if (stalls) begin
                cmd_ready = ($urandom % 4) != 0;
                data_ready = ($urandom % 4) != 0;
            end else begin
                cmd_ready = 1'b1;
                data_ready = 1'b1;
            end
            cmd_held = cmd_valid && !cmd_ready;
            data_held = data_valid && !data_ready;
            cmd_prev = cmd;
            data_prev = data_out;
            // both high here means a transfer on the next rising edge
            if (cmd_valid && cmd_ready) begin
                got_cmds.push_back(cmd);
                done = cmd.stop;
            end
            if (data_valid && data_ready) begin
                got_data.push_back(data_out);
            end
        end
        // stop goes across on this edge before the readies drop
        @(negedge clk);
        cmd_ready = 1'b0;
        data_ready = 1'b0;
        run_cycles = n;
    endtask

    task automatic compare_streams();
        check_value("cmd count", 32'(exp_cmds.size()), 32'(got_cmds.size()));
        check_value("data count", 32'(exp_data.size()), 32'(got_data.size()));
        foreach (exp_cmds[i]) begin
            check_value($sformatf("cmd %0d", i), 32'(exp_cmds[i]), 32'(got_cmds[i]));
        end
        foreach (exp_data[i]) begin
            check_value($sformatf("data %0d", i), 32'(exp_data[i]), 32'(got_data[i]));
        end
    endtask

    task automatic outputs_quiet();
        check_value("cmd_valid", 32'd0, 32'(cmd_valid));
        check_value("data_valid", 32'd0, 32'(data_valid));
        check_value("busy", 32'd0, 32'(busy));
    endtask

    // busy falls a cycle or two after the stop
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n == IDLE_TIMEOUT) begin
                report_timeout("busy did not fall after the stop command");
            end
        end
        outputs_quiet();
    endtask

    task automatic pulse_start();
        @(negedge clk);
        init_start = 1'b1;
        @(negedge clk);
        init_start = 1'b0;
        check_value("busy after start", 32'd1, 32'(busy));
    endtask

    task automatic idle_after_reset();
        test_name = "reset_idle";
        outputs_quiet();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            outputs_quiet();
        end
    endtask

    task automatic full_run_no_stall();
        test_name = "full_run";
        build_expected(0, 8'hae);
        pulse_start();
        collect_run(1'b0);
        full_run_cycles = run_cycles;
        compare_streams();
        wait_idle();
    endtask

    task automatic full_run_with_stalls();
        test_name = "stalled_run";
        build_expected(0, 8'hae);
        pulse_start();
        collect_run(1'b1);
        compare_streams();
        wait_idle();
    endtask

    // one pin change replays only the last codec write
    task automatic apply_config(input logic spk, input logic mic);
        build_expected(NUM_GROUPS - 1, expected_sel1(spk, mic));
        @(negedge clk);
        spk_enable = spk;
        mic_boost = mic;
        collect_run(1'b0);
        compare_streams();
        wait_idle();
    endtask

    task automatic config_change_replay();
        test_name = "cfg_replay";
        apply_config(1'b1, 1'b0);
        apply_config(1'b1, 1'b1);
    endtask

    task automatic held_start_single_run();
        test_name = "held_start";
        // table now carries the last patched byte
        build_expected(0, expected_sel1(1'b1, 1'b1));
        @(negedge clk);
        init_start = 1'b1;
        collect_run(1'b1);
        compare_streams();
        wait_idle();
        // request still held and no second run may start
        for (int i = 0; i < 2 * full_run_cycles; i++) begin
            @(negedge clk);
            outputs_quiet();
        end
        @(negedge clk);
        init_start = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        init_start = 1'b0;
        spk_enable = 1'b0;
        mic_boost = 1'b0;
        cmd_ready = 1'b0;
        data_ready = 1'b0;
        test_name = "setup";
        run_cycles = 0;
        full_run_cycles = 0;
        void'($urandom(SEED));
        repeat (2) @(negedge clk);
        rst = 1'b0;

        idle_after_reset();
        full_run_no_stall();
        full_run_with_stalls();
        config_change_replay();
        held_start_single_run();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
init_table_pkg.sv
i2c_cmd_pkg.sv
cfg_sync.sv
init_table.sv
init_sequencer.sv
i2c_cmd_out.sv
codec_init_top.sv
tb_codec_init.sv

// File: Makefile
SIM := obj_dir/Vtb_codec_init
SRCS := $(wildcard *.sv)

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): $(SRCS) files.f
	verilator --binary -Wno-fatal --top-module tb_codec_init -f files.f -o Vtb_codec_init

clean:
	rm -rf obj_dir
